//--- Makefile
# Verilator build and run for the matrix-vector engine testbench

SRCS := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_mv_top: sim.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_mv_top -f sim.f

# Pass or fail comes from the log
run: obj_dir/Vtb_mv_top
	./obj_dir/Vtb_mv_top | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/a_loader.sv
`timescale 1ns/1ps

module a_loader (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                a_restart,
  input  logic                                a_valid,
  output logic                                a_ready,
  input  mv_pkg::data_t                       a_bram_dout,
  output logic                                a_bram_enb,
  output mv_pkg::a_addr_t                     a_bram_addrb,
  output mv_pkg::data_t [mv_pkg::A_DEPTH-1:0] vec
);

  mv_pkg::a_addr_t                  rd_cnt;   // Next address to issue
  mv_pkg::a_addr_t                  wr_cnt;   // Words captured so far
  logic                             rd_en;
  logic                             rd_en_q;  // Data valid from the RAM
  logic [mv_pkg::A_INDEX_WIDTH-1:0] wr_idx;

  // ****************************************
  // Read side
  // ****************************************

  // Counter parks at A_DEPTH once every word is requested
  assign rd_en        = a_valid && !a_restart && (rd_cnt < mv_pkg::A_DEPTH);
  assign a_bram_enb   = rd_en;
  assign a_bram_addrb = rd_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_cnt <= '0;
    end else if (a_restart) begin
      rd_cnt <= '0;
    end else if (rd_en) begin
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  // One-cycle RAM latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_q <= 1'b0;
    end else if (a_restart) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
  end

  // ****************************************
  // Capture side
  // ****************************************

  assign wr_idx  = wr_cnt[mv_pkg::A_INDEX_WIDTH-1:0];
  assign a_ready = (wr_cnt == mv_pkg::a_addr_t'(mv_pkg::A_DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
    end else if (a_restart) begin
      wr_cnt <= '0;
    end else if (rd_en_q) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // Vector survives a restart, so a reuse run sees the old A
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      vec[wr_idx] <= a_bram_dout;
    end
  end

  // Each returned word must land inside the register file
  a_wr_range: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en_q |-> (wr_cnt < mv_pkg::A_DEPTH))
    else $error("A write index out of range: %0d", wr_cnt);

endmodule

//--- hdl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            cmd_valid,
  input  mv_pkg::cmd_op_t cmd_op,
  input  mv_pkg::row_t    cmd_rows,
  input  logic            a_ready,
  input  logic            wr_done,
  output logic            a_restart,
  output logic            a_valid,
  output logic            run_start,
  output mv_pkg::row_t    run_rows,
  output logic            busy,
  output logic            done
);

  mv_pkg::dec_state_t state;
  mv_pkg::row_t       rows_clamped;
  logic               start_cmd;

  // Only run opcodes start anything and only when idle
  assign start_cmd = cmd_valid && (state == mv_pkg::S_IDLE) &&
                     ((cmd_op == mv_pkg::OP_RUN_LOAD) || (cmd_op == mv_pkg::OP_RUN_REUSE));

  always_comb begin
    if (cmd_rows == '0) begin
      rows_clamped = mv_pkg::row_t'(1);
    end else if (cmd_rows > mv_pkg::ROWS) begin
      rows_clamped = mv_pkg::row_t'(mv_pkg::ROWS);
    end else begin
      rows_clamped = cmd_rows;
    end
  end

  assign a_valid = (state == mv_pkg::S_LOAD);
  assign busy    = (state != mv_pkg::S_IDLE);  // Falls together with done

  // ****************************************
  // Run sequencer
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= mv_pkg::S_IDLE;
      a_restart <= 1'b0;
      run_start <= 1'b0;
      done      <= 1'b0;
      run_rows  <= '0;
    end else begin
      a_restart <= 1'b0;
      run_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        mv_pkg::S_IDLE: begin
          if (start_cmd) begin
            run_rows <= rows_clamped;
            if (cmd_op == mv_pkg::OP_RUN_LOAD) begin
              state     <= mv_pkg::S_LOAD;
              a_restart <= 1'b1;
            end else begin
              state     <= mv_pkg::S_RUN;  // Reuse skips the load
              run_start <= 1'b1;
            end
          end
        end
        mv_pkg::S_LOAD: begin
          // a_ready is stale while the restart pulse is still out
          if (a_ready && !a_restart) begin
            state     <= mv_pkg::S_RUN;
            run_start <= 1'b1;
          end
        end
        mv_pkg::S_RUN: begin
          state <= mv_pkg::S_WAIT;
        end
        mv_pkg::S_WAIT: begin
          if (wr_done) begin
            state <= mv_pkg::S_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= mv_pkg::S_IDLE;
      endcase
    end
  end

  // Last write of a run only lands while waiting for it
  a_done_order: assert property (@(posedge clk) disable iff (!rst_n)
    wr_done |-> (state == mv_pkg::S_WAIT))
    else $error("wr_done arrived outside S_WAIT");

endmodule

//--- hdl/dot_engine.sv
`timescale 1ns/1ps

module dot_engine (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                run_start,
  input  mv_pkg::row_t                        run_rows,
  input  mv_pkg::data_t [mv_pkg::A_DEPTH-1:0] vec,
  input  mv_pkg::data_t                       b_bram_dout,
  output logic                                b_bram_enb,
  output mv_pkg::b_addr_t                     b_bram_addrb,
  output logic                                row_valid,
  output mv_pkg::acc_t                        row_sum,
  output mv_pkg::row_t                        row_idx
);

  logic                             issuing;
  logic [mv_pkg::A_INDEX_WIDTH-1:0] col_cnt;
  mv_pkg::row_t                     row_cnt;
  logic                             last_col;
  logic                             last_row;

  // Stage 1 tags aligned with b_bram_dout
  logic                             s1_valid;
  logic [mv_pkg::A_INDEX_WIDTH-1:0] s1_col;
  logic                             s1_last;
  mv_pkg::row_t                     s1_row;

  mv_pkg::acc_t                     product;

  // ****************************************
  // Address issue
  // ****************************************

  assign last_col = (col_cnt == mv_pkg::A_INDEX_WIDTH'(mv_pkg::A_DEPTH - 1));
  assign last_row = (row_cnt == mv_pkg::row_t'(run_rows - 1'b1));

  assign b_bram_enb   = issuing;
  assign b_bram_addrb = mv_pkg::b_addr_t'(row_cnt * mv_pkg::A_DEPTH + col_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issuing <= 1'b0;
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (run_start) begin
      issuing <= 1'b1;
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (issuing) begin
      if (last_col) begin
        col_cnt <= '0;
        row_cnt <= row_cnt + 1'b1;  // Next row right behind
        if (last_row) begin
          issuing <= 1'b0;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // ****************************************
  // Tag pipeline and MAC
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      s1_valid  <= issuing;
      row_valid <= s1_valid && s1_last;  // Sum complete after last column
    end
  end

  always_ff @(posedge clk) begin
    s1_col  <= col_cnt;
    s1_last <= last_col;
    s1_row  <= row_cnt;
    row_idx <= s1_row;
  end

  assign product = mv_pkg::acc_t'(vec[s1_col]) * mv_pkg::acc_t'(b_bram_dout);

  // Column zero opens a fresh sum
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      if (s1_col == '0) begin
        row_sum <= product;
      end else begin
        row_sum <= row_sum + product;
      end
    end
  end

  // Sequencer must wait for the previous run to drain
  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    run_start |-> !issuing)
    else $error("run_start while B rows still issuing");

endmodule

//--- hdl/mv_pkg.sv
package mv_pkg;

  // ****************************************
  // Sizes
  // ****************************************

  localparam int DATA_WIDTH    = 16;
  localparam int A_DEPTH       = 8;   // Vector length and B row length
  localparam int A_ADDR_W      = 4;   // Wide enough to reach A_DEPTH
  localparam int A_INDEX_WIDTH = 3;
  localparam int ROWS          = 8;   // Max rows per run
  localparam int ROW_W         = 4;   // Holds 1 to ROWS
  localparam int B_ADDR_W      = 6;   // row * A_DEPTH + col

  // Full-precision row sum with no overflow over A_DEPTH products
  localparam int ACC_WIDTH     = 2 * DATA_WIDTH + $clog2(A_DEPTH);

  // ****************************************
  // Vector types
  // ****************************************

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ACC_WIDTH-1:0]  acc_t;
  typedef logic [ROW_W-1:0]      row_t;
  typedef logic [A_ADDR_W-1:0]   a_addr_t;
  typedef logic [B_ADDR_W-1:0]   b_addr_t;

  // ****************************************
  // Enums
  // ****************************************

  // Command opcodes
  typedef enum logic [1:0] {
    OP_NOP       = 2'd0,
    OP_RUN_LOAD  = 2'd1,  // Fetch A, then run
    OP_RUN_REUSE = 2'd2   // Run on the A already held
  } cmd_op_t;

  // Run sequencer states
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_LOAD = 2'd1,
    S_RUN  = 2'd2,
    S_WAIT = 2'd3
  } dec_state_t;

endpackage

//--- hdl/mv_top.sv
`timescale 1ns/1ps

module mv_top (
  input  logic            clk,
  input  logic            rst_n,
  // Command
  input  logic            cmd_valid,
  input  mv_pkg::cmd_op_t cmd_op,
  input  mv_pkg::row_t    cmd_rows,
  // A memory
  output logic            a_bram_enb,
  output mv_pkg::a_addr_t a_bram_addrb,
  input  mv_pkg::data_t   a_bram_dout,
  // B memory
  output logic            b_bram_enb,
  output mv_pkg::b_addr_t b_bram_addrb,
  input  mv_pkg::data_t   b_bram_dout,
  // Result memory
  output logic            res_we,
  output mv_pkg::row_t    res_addr,
  output mv_pkg::acc_t    res_wdata,
  // Status
  output logic            busy,
  output logic            done
);

  // ****************************************
  // Internal wires
  // ****************************************

  logic                                a_restart;
  logic                                a_valid;
  logic                                a_ready;
  logic                                run_start;
  mv_pkg::row_t                        run_rows;
  mv_pkg::data_t [mv_pkg::A_DEPTH-1:0] vec;
  logic                                row_valid;
  mv_pkg::acc_t                        row_sum;
  mv_pkg::row_t                        row_idx;
  logic                                wr_done;

  // ****************************************
  // Decode
  // ****************************************

  cmd_decode cmd_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_rows  (cmd_rows),
    .a_ready   (a_ready),
    .wr_done   (wr_done),
    .a_restart (a_restart),
    .a_valid   (a_valid),
    .run_start (run_start),
    .run_rows  (run_rows),
    .busy      (busy),
    .done      (done)
  );

  // ****************************************
  // Execute
  // ****************************************

  a_loader a_loader_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .a_restart    (a_restart),
    .a_valid      (a_valid),
    .a_ready      (a_ready),
    .a_bram_dout  (a_bram_dout),
    .a_bram_enb   (a_bram_enb),
    .a_bram_addrb (a_bram_addrb),
    .vec          (vec)
  );

  dot_engine dot_engine_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .run_start    (run_start),
    .run_rows     (run_rows),
    .vec          (vec),
    .b_bram_dout  (b_bram_dout),
    .b_bram_enb   (b_bram_enb),
    .b_bram_addrb (b_bram_addrb),
    .row_valid    (row_valid),
    .row_sum      (row_sum),
    .row_idx      (row_idx)
  );

  // Results
  result_writer result_writer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_start (run_start),
    .run_rows  (run_rows),
    .row_valid (row_valid),
    .row_sum   (row_sum),
    .row_idx   (row_idx),
    .res_we    (res_we),
    .res_addr  (res_addr),
    .res_wdata (res_wdata),
    .wr_done   (wr_done)
  );

endmodule

//--- hdl/result_writer.sv
`timescale 1ns/1ps

module result_writer (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         run_start,
  input  mv_pkg::row_t run_rows,
  input  logic         row_valid,
  input  mv_pkg::acc_t row_sum,
  input  mv_pkg::row_t row_idx,
  output logic         res_we,
  output mv_pkg::row_t res_addr,
  output mv_pkg::acc_t res_wdata,
  output logic         wr_done
);

  mv_pkg::row_t wr_cnt;       // Writes since run_start
  mv_pkg::row_t wr_cnt_next;

  assign wr_cnt_next = wr_cnt + 1'b1;

  // ****************************************
  // Write strobe and row count
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_we  <= 1'b0;
      wr_done <= 1'b0;
      wr_cnt  <= '0;
    end else begin
      res_we  <= row_valid;
      wr_done <= row_valid && (wr_cnt_next == run_rows);  // Same cycle as last write
      if (run_start) begin
        wr_cnt <= '0;
      end else if (row_valid) begin
        wr_cnt <= wr_cnt_next;
      end
    end
  end

  // Result port payload
  always_ff @(posedge clk) begin
    if (row_valid) begin
      res_addr  <= row_idx;
      res_wdata <= row_sum;
    end
  end

  // Rows must come back in issue order with none skipped
  a_row_order: assert property (@(posedge clk) disable iff (!rst_n)
    row_valid |-> (row_idx == wr_cnt))
    else $error("Row %0d arrived, expected %0d", row_idx, wr_cnt);

endmodule

//--- sim.f
hdl/mv_pkg.sv
hdl/cmd_decode.sv
hdl/a_loader.sv
hdl/dot_engine.sv
hdl/result_writer.sv
hdl/mv_top.sv
tests/bram_model.sv
tests/tb_mv_top.sv

//--- tests/bram_model.sv
`timescale 1ns/1ps

module bram_model #(
  parameter int ADDR_W = 4,
  parameter int DEPTH  = 2 ** ADDR_W
) (
  input  logic              clk,
  // Read port for the DUT
  input  logic              enb,
  input  logic [ADDR_W-1:0] addrb,
  output mv_pkg::data_t     doutb,
  // Fill port for the testbench
  input  logic              fill_we,
  input  logic [ADDR_W-1:0] fill_addr,
  input  mv_pkg::data_t     fill_data
);

  mv_pkg::data_t mem [DEPTH];

  // ****************************************
  // Fill and read
  // ****************************************

  always_ff @(posedge clk) begin
    if (fill_we) begin
      mem[fill_addr] <= fill_data;
    end
  end

  // Data shows up one cycle after an enabled address
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

//--- tests/tb_mv_top.sv
`timescale 1ns/1ps

module tb_mv_top;

  localparam int NUM_TESTS       = 7;
  localparam int CMD_LIMIT       = mv_pkg::ROWS * mv_pkg::A_DEPTH + 40;  // Cycles per test
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CMD_LIMIT;

  logic            clk;
  logic            rst_n;
  logic            cmd_valid;
  mv_pkg::cmd_op_t cmd_op;
  mv_pkg::row_t    cmd_rows;
  logic            a_bram_enb;
  mv_pkg::a_addr_t a_bram_addrb;
  mv_pkg::data_t   a_bram_dout;
  logic            b_bram_enb;
  mv_pkg::b_addr_t b_bram_addrb;
  mv_pkg::data_t   b_bram_dout;
  logic            res_we;
  mv_pkg::row_t    res_addr;
  mv_pkg::acc_t    res_wdata;
  logic            busy;
  logic            done;

  logic            a_fill_we;
  mv_pkg::a_addr_t a_fill_addr;
  mv_pkg::data_t   a_fill_data;
  logic            b_fill_we;
  mv_pkg::b_addr_t b_fill_addr;
  mv_pkg::data_t   b_fill_data;

  // Testbench copies of memory contents
  mv_pkg::data_t   a_mem_copy [mv_pkg::A_DEPTH];
  mv_pkg::data_t   a_ref [mv_pkg::A_DEPTH];  // A as of the last load command
  mv_pkg::data_t   b_copy [mv_pkg::ROWS * mv_pkg::A_DEPTH];

  mv_pkg::row_t    exp_addr_q [$];
  mv_pkg::acc_t    exp_sum_q [$];
  mv_pkg::row_t    exp_addr;
  mv_pkg::acc_t    exp_sum;
  string           test_name;
  int              value_errs;
  int              other_errs;
  int              done_count;
  int              accepted_count;

  mv_top mv_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_rows     (cmd_rows),
    .a_bram_enb   (a_bram_enb),
    .a_bram_addrb (a_bram_addrb),
    .a_bram_dout  (a_bram_dout),
    .b_bram_enb   (b_bram_enb),
    .b_bram_addrb (b_bram_addrb),
    .b_bram_dout  (b_bram_dout),
    .res_we       (res_we),
    .res_addr     (res_addr),
    .res_wdata    (res_wdata),
    .busy         (busy),
    .done         (done)
  );

  bram_model #(.ADDR_W(mv_pkg::A_ADDR_W)) a_mem_inst (
    .clk       (clk),
    .enb       (a_bram_enb),
    .addrb     (a_bram_addrb),
    .doutb     (a_bram_dout),
    .fill_we   (a_fill_we),
    .fill_addr (a_fill_addr),
    .fill_data (a_fill_data)
  );

  bram_model #(.ADDR_W(mv_pkg::B_ADDR_W)) b_mem_inst (
    .clk       (clk),
    .enb       (b_bram_enb),
    .addrb     (b_bram_addrb),
    .doutb     (b_bram_dout),
    .fill_we   (b_fill_we),
    .fill_addr (b_fill_addr),
    .fill_data (b_fill_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ****************************************
  // Reference model
  // ****************************************

  function automatic mv_pkg::acc_t row_dot(input int row);
    mv_pkg::acc_t sum;
    sum = '0;
    for (int c = 0; c < mv_pkg::A_DEPTH; c++) begin
      sum += mv_pkg::acc_t'(a_ref[c]) * mv_pkg::acc_t'(b_copy[row * mv_pkg::A_DEPTH + c]);
    end
    return sum;
  endfunction

  function automatic int clamp_rows(input mv_pkg::row_t rows);
    if (rows == 0) begin
      return 1;
    end
    return (rows > mv_pkg::ROWS) ? mv_pkg::ROWS : int'(rows);
  endfunction

  // ****************************************
  // Stimulus tasks
  // ****************************************

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_a();
    for (int i = 0; i < mv_pkg::A_DEPTH; i++) begin
      step();
      a_fill_we     = 1'b1;
      a_fill_addr   = mv_pkg::a_addr_t'(i);
      a_fill_data   = mv_pkg::data_t'($urandom);
      a_mem_copy[i] = a_fill_data;
    end
    step();
    a_fill_we = 1'b0;
  endtask

  task automatic fill_b();
    for (int i = 0; i < mv_pkg::ROWS * mv_pkg::A_DEPTH; i++) begin
      step();
      b_fill_we   = 1'b1;
      b_fill_addr = mv_pkg::b_addr_t'(i);
      b_fill_data = mv_pkg::data_t'($urandom);
      b_copy[i]   = b_fill_data;
    end
    step();
    b_fill_we = 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!busy && !done && !res_we && !a_bram_enb && !b_bram_enb) else begin
        other_errs++;
        $display("%s: DUT output active while no command is running", test_name);
      end
    end
  endtask

  // Strobe one command and queue its expected results
  task automatic issue_cmd(input mv_pkg::cmd_op_t op, input mv_pkg::row_t rows);
    int eff;
    step();
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_rows  = rows;
    if (op == mv_pkg::OP_RUN_LOAD) begin
      a_ref = a_mem_copy;
    end
    eff = clamp_rows(rows);
    for (int r = 0; r < eff; r++) begin
      exp_addr_q.push_back(mv_pkg::row_t'(r));
      exp_sum_q.push_back(row_dot(r));
    end
    accepted_count++;
    step();
    cmd_valid = 1'b0;
  endtask

  task automatic wait_done();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < CMD_LIMIT && !seen; n++) begin
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      other_errs++;
      $display("%s: timed out waiting for done", test_name);
    end
  endtask

  task automatic run_cmd(input string name, input mv_pkg::cmd_op_t op, input mv_pkg::row_t rows);
    test_name = name;
    issue_cmd(op, rows);
    wait_done();
  endtask

  // ****************************************
  // Result and done checking
  // ****************************************

  always @(negedge clk) begin
    // Done is checked before this cycle's write so it must trail the last one
    if (rst_n && done) begin
      done_count++;
      assert (exp_addr_q.size() == 0) else begin
        other_errs++;
        $display("%s: done came with %0d results not yet written", test_name,
                 exp_addr_q.size());
      end
      assert (!busy) else begin
        other_errs++;
        $display("%s: busy still high in the done cycle", test_name);
      end
    end
    if (rst_n && res_we) begin
      if (exp_addr_q.size() == 0) begin
        other_errs++;
        $display("%s: unexpected result write at address %0d", test_name, res_addr);
      end else begin
        exp_addr = exp_addr_q.pop_front();
        exp_sum  = exp_sum_q.pop_front();
        assert (res_addr == exp_addr) else begin
          value_errs++;
          $display("FAILED %s res_addr: expected %0d, actual %0d", test_name, exp_addr, res_addr);
        end
        assert (res_wdata == exp_sum) else begin
          value_errs++;
          $display("FAILED %s res_wdata: expected %0h, actual %0h", test_name, exp_sum,
                   res_wdata);
        end
      end
    end
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = mv_pkg::OP_NOP;
    cmd_rows    = '0;
    a_fill_we   = 1'b0;
    a_fill_addr = '0;
    a_fill_data = '0;
    b_fill_we   = 1'b0;
    b_fill_addr = '0;
    b_fill_data = '0;
    value_errs     = 0;
    other_errs     = 0;
    done_count     = 0;
    accepted_count = 0;
    void'($urandom(98));
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    test_name = "idle_after_reset";
    check_idle(4);
    fill_b();
    fill_a();
    check_idle(8);

    run_cmd("load_all_rows", mv_pkg::OP_RUN_LOAD, mv_pkg::row_t'(mv_pkg::ROWS));

    fill_a();  // Reuse must ignore this new A
    run_cmd("reuse_after_refill", mv_pkg::OP_RUN_REUSE, mv_pkg::row_t'(mv_pkg::ROWS));

    run_cmd("rows_1", mv_pkg::OP_RUN_LOAD, mv_pkg::row_t'(1));
    run_cmd("rows_3", mv_pkg::OP_RUN_REUSE, mv_pkg::row_t'(3));
    run_cmd("rows_0_clamped", mv_pkg::OP_RUN_LOAD, mv_pkg::row_t'(0));

    test_name = "strobe_while_busy";
    issue_cmd(mv_pkg::OP_RUN_LOAD, mv_pkg::row_t'(mv_pkg::ROWS));
    repeat (5) step();
    assert (busy) else begin
      other_errs++;
      $display("%s: busy low in the middle of a run", test_name);
    end
    cmd_valid = 1'b1;
    cmd_op    = mv_pkg::OP_RUN_LOAD;
    cmd_rows  = mv_pkg::row_t'(2);
    step();
    cmd_valid = 1'b0;
    wait_done();
    check_idle(20);  // Stray strobe must not start a second run

    assert (done_count == accepted_count) else begin
      value_errs++;
      $display("FAILED done_count: expected %0d, actual %0d", accepted_count, done_count);
    end
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
